// ==== common/regbus_pkg.sv ====
package regbus_pkg;

  // request kind on the internal register bus
  typedef enum logic {
    ACCESS_READ  = 1'b0,
    ACCESS_WRITE = 1'b1
  } reg_access_e;

  // same codes as AXI RRESP/BRESP
  typedef enum logic [1:0] {
    STATUS_OKAY   = 2'b00,
    STATUS_SLVERR = 2'b10
  } reg_status_e;

  // local byte offsets inside the timer window
  localparam logic [7:0] CTRL_OFFSET    = 8'h00;
  localparam logic [7:0] COMPARE_OFFSET = 8'h04;
  localparam logic [7:0] COUNT_OFFSET   = 8'h08;
  localparam logic [7:0] STATUS_OFFSET  = 8'h0c;

  // CTRL fields
  localparam int CTRL_ENABLE_BIT   = 0;
  localparam int CTRL_PRESCALE_LSB = 8;

endpackage

// ==== axi_lite/axi_lite_adapter.sv ====
`timescale 1ns/1ns
module axi_lite_adapter
  import regbus_pkg::*;
#(
  parameter int ADDRESS_WIDTH = 16,
  parameter int DATA_WIDTH    = 32
)(
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      s_awvalid,
  output logic                      s_awready,
  input  logic [ADDRESS_WIDTH-1:0]  s_awaddr,
  input  logic                      s_wvalid,
  output logic                      s_wready,
  input  logic [DATA_WIDTH-1:0]     s_wdata,
  input  logic [DATA_WIDTH/8-1:0]   s_wstrb,
  output logic                      s_bvalid,
  input  logic                      s_bready,
  output logic [1:0]                s_bresp,
  input  logic                      s_arvalid,
  output logic                      s_arready,
  input  logic [ADDRESS_WIDTH-1:0]  s_araddr,
  output logic                      s_rvalid,
  input  logic                      s_rready,
  output logic [DATA_WIDTH-1:0]     s_rdata,
  output logic [1:0]                s_rresp,
  output logic                      req_valid,
  output reg_access_e               req_access,
  output logic [ADDRESS_WIDTH-1:0]  req_address,
  output logic [DATA_WIDTH-1:0]     req_write_data,
  output logic [DATA_WIDTH/8-1:0]   req_strobe,
  input  logic                      req_ready,
  input  reg_status_e               req_status,
  input  logic [DATA_WIDTH-1:0]     req_read_data
);

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    READ_RESP,
    WRITE_RESP
  } state_e;

  state_e state;
  logic   write_accept;

  // read wins when both arrive together
  assign write_accept = (state == IDLE) && !s_arvalid && s_awvalid && s_wvalid;

  assign s_arready = (state == IDLE);
  assign s_awready = write_accept; // aw and w taken together
  assign s_wready  = write_accept;
  assign req_valid = (state == REQUEST);
  assign s_rvalid  = (state == READ_RESP);
  assign s_bvalid  = (state == WRITE_RESP);

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (s_arvalid || write_accept) begin
            state <= REQUEST;
          end
        end
        REQUEST: begin
          if (req_ready) begin
            state <= (req_access == ACCESS_READ) ? READ_RESP : WRITE_RESP;
          end
        end
        READ_RESP: begin
          if (s_rready) begin
            state <= IDLE;
          end
        end
        WRITE_RESP: begin
          if (s_bready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == IDLE && s_arvalid) begin
      req_access  <= ACCESS_READ;
      req_address <= s_araddr;
    end else if (write_accept) begin
      req_access     <= ACCESS_WRITE;
      req_address    <= s_awaddr;
      req_write_data <= s_wdata;
      req_strobe     <= s_wstrb;
    end
    if (state == REQUEST && req_ready) begin
      s_rdata <= req_read_data; // held until rready
      s_rresp <= req_status;
      s_bresp <= req_status;
    end
  end

endmodule

// ==== src/reg_decoder.sv ====
`timescale 1ns/1ns
module reg_decoder
  import regbus_pkg::*;
#(
  parameter int                     ADDRESS_WIDTH       = 16,
  parameter int                     LOCAL_ADDRESS_WIDTH = 8,
  parameter int                     DATA_WIDTH          = 32,
  parameter int                     REGISTERS           = 4,
  parameter bit [ADDRESS_WIDTH-1:0] BASE_ADDRESS        = '0,
  parameter int                     BYTE_SIZE           = 16,
  parameter bit                     ERROR_STATUS        = 1,
  parameter bit [DATA_WIDTH-1:0]    DEFAULT_READ_DATA   = '0
)(
  input  logic                                           i_clk,
  input  logic                                           i_rst_n,
  input  logic                                           req_valid,
  input  reg_access_e                                    req_access,
  input  logic [ADDRESS_WIDTH-1:0]                       req_address,
  input  logic [DATA_WIDTH-1:0]                          req_write_data,
  input  logic [DATA_WIDTH/8-1:0]                        req_strobe,
  output logic                                           req_ready,
  output reg_status_e                                    req_status,
  output logic [DATA_WIDTH-1:0]                          req_read_data,
  output logic [REGISTERS-1:0]                           slot_valid,
  output reg_access_e [REGISTERS-1:0]                    slot_access,
  output logic [REGISTERS-1:0][LOCAL_ADDRESS_WIDTH-1:0]  slot_address,
  output logic [REGISTERS-1:0][DATA_WIDTH-1:0]           slot_write_data,
  output logic [REGISTERS-1:0][DATA_WIDTH/8-1:0]         slot_strobe,
  input  logic [REGISTERS-1:0]                           slot_active,
  input  logic [REGISTERS-1:0]                           slot_ready,
  input  reg_status_e [REGISTERS-1:0]                    slot_status,
  input  logic [REGISTERS-1:0][DATA_WIDTH-1:0]           slot_read_data
);

  localparam reg_status_e DEFAULT_STATUS = ERROR_STATUS ? STATUS_SLVERR : STATUS_OKAY;
  localparam logic [ADDRESS_WIDTH:0] END_ADDRESS =
    (ADDRESS_WIDTH + 1)'(BASE_ADDRESS + BYTE_SIZE - 1);

  logic                  busy;
  logic                  inside_range;
  logic                  inactive;
  logic [1:0]            sel_status;
  logic [DATA_WIDTH-1:0] sel_read_data;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy <= 1'b0;
    end else begin
      busy <= req_valid && req_ready; // access completes this cycle
    end
  end

  assign inside_range = (req_address >= BASE_ADDRESS) &&
                        ({1'b0, req_address} <= END_ADDRESS);

  for (genvar i = 0; i < REGISTERS; i++) begin : g_request
    assign slot_valid[i]      = req_valid && inside_range && !busy;
    assign slot_access[i]     = req_access;
    assign slot_address[i]    = req_address[LOCAL_ADDRESS_WIDTH-1:0];
    assign slot_write_data[i] = req_write_data;
    assign slot_strobe[i]     = req_strobe;
  end

  // slots are one-hot, so an or-mux is enough
  always_comb begin
    sel_status    = '0;
    sel_read_data = '0;
    for (int i = 0; i < REGISTERS; i++) begin
      if (slot_active[i]) begin
        sel_status    = sel_status | slot_status[i];
        sel_read_data = sel_read_data | slot_read_data[i];
      end
    end
  end

  assign inactive      = !inside_range || (slot_active == '0);
  assign req_ready     = (slot_ready != '0) || inactive;
  assign req_status    = inactive ? DEFAULT_STATUS : reg_status_e'(sel_status);
  assign req_read_data = inactive ? DEFAULT_READ_DATA : sel_read_data;

endmodule

// ==== src/reg_slot.sv ====
`timescale 1ns/1ns
module reg_slot
  import regbus_pkg::*;
#(
  parameter int                           LOCAL_ADDRESS_WIDTH = 8,
  parameter int                           DATA_WIDTH          = 32,
  parameter bit [LOCAL_ADDRESS_WIDTH-1:0] OFFSET              = '0,
  parameter bit [DATA_WIDTH-1:0]          RESET_VALUE         = '0,
  parameter bit [DATA_WIDTH-1:0]          WRITE_MASK          = '0,
  parameter bit [DATA_WIDTH-1:0]          W1C_MASK            = '0
)(
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           slot_valid,
  input  reg_access_e                    slot_access,
  input  logic [LOCAL_ADDRESS_WIDTH-1:0] slot_address,
  input  logic [DATA_WIDTH-1:0]          slot_write_data,
  input  logic [DATA_WIDTH/8-1:0]        slot_strobe,
  output logic                           slot_active,
  output logic                           slot_ready,
  output reg_status_e                    slot_status,
  output logic [DATA_WIDTH-1:0]          slot_read_data,
  input  logic [DATA_WIDTH-1:0]          hw_value,
  input  logic [DATA_WIDTH-1:0]          hw_set,
  output logic [DATA_WIDTH-1:0]          value
);

  localparam bit [DATA_WIDTH-1:0] STORED_MASK = WRITE_MASK | W1C_MASK;

  logic [DATA_WIDTH-1:0] bit_strobe;
  logic [DATA_WIDTH-1:0] value_q;
  logic [DATA_WIDTH-1:0] value_next;
  logic                  write_hit;

  always_comb begin
    for (int i = 0; i < DATA_WIDTH / 8; i++) begin
      bit_strobe[8*i+:8] = {8{slot_strobe[i]}};
    end
  end

  assign slot_active = (slot_address == OFFSET);
  assign slot_ready  = slot_valid && slot_active;
  assign slot_status = STATUS_OKAY;
  assign write_hit   = slot_ready && (slot_access == ACCESS_WRITE);

  always_comb begin
    value_next = value_q;
    if (write_hit) begin
      value_next = (value_q & ~(WRITE_MASK & bit_strobe)) |
                   (slot_write_data & WRITE_MASK & bit_strobe);
      value_next = value_next & ~(W1C_MASK & bit_strobe & slot_write_data);
    end
    value_next = value_next | (hw_set & STORED_MASK); // set beats clear
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      value_q <= RESET_VALUE & STORED_MASK;
    end else begin
      value_q <= value_next;
    end
  end

  assign value          = (value_q & STORED_MASK) | (hw_value & ~STORED_MASK);
  assign slot_read_data = value;

endmodule

// ==== timer/timer_core.sv ====
`timescale 1ns/1ns
module timer_core #(
  parameter int DATA_WIDTH     = 32,
  parameter int PRESCALE_WIDTH = 8
)(
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      tmr_enable,
  input  logic [PRESCALE_WIDTH-1:0] tmr_prescale,
  input  logic [DATA_WIDTH-1:0]     tmr_compare,
  output logic [DATA_WIDTH-1:0]     tmr_count,
  output logic                      tmr_match_pulse
);

  logic [PRESCALE_WIDTH-1:0] prescale_count;
  logic                      tick;

  assign tick = tmr_enable && (prescale_count == tmr_prescale);

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      prescale_count <= '0;
    end else if (!tmr_enable || tick) begin
      prescale_count <= '0; // restart divider
    end else begin
      prescale_count <= prescale_count + 1'b1;
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      tmr_count       <= '0;
      tmr_match_pulse <= 1'b0;
    end else begin
      tmr_match_pulse <= 1'b0;
      if (tick) begin
        if (tmr_count == tmr_compare) begin
          tmr_count       <= '0;
          tmr_match_pulse <= 1'b1;
        end else begin
          tmr_count <= tmr_count + 1'b1;
        end
      end
    end
  end

endmodule

// ==== src/timer_top.sv ====
`timescale 1ns/1ns
module timer_top
  import regbus_pkg::*;
#(
  parameter int                     ADDRESS_WIDTH       = 16,
  parameter int                     LOCAL_ADDRESS_WIDTH = 8,
  parameter int                     DATA_WIDTH          = 32,
  parameter int                     REGISTERS           = 4,
  parameter bit [ADDRESS_WIDTH-1:0] BASE_ADDRESS        = 16'h0100,
  parameter int                     BYTE_SIZE           = 16,
  parameter bit                     ERROR_STATUS        = 1,
  parameter bit [DATA_WIDTH-1:0]    DEFAULT_READ_DATA   = 32'hdead_beef
)(
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     s_awvalid,
  output logic                     s_awready,
  input  logic [ADDRESS_WIDTH-1:0] s_awaddr,
  input  logic                     s_wvalid,
  output logic                     s_wready,
  input  logic [DATA_WIDTH-1:0]    s_wdata,
  input  logic [DATA_WIDTH/8-1:0]  s_wstrb,
  output logic                     s_bvalid,
  input  logic                     s_bready,
  output logic [1:0]               s_bresp,
  input  logic                     s_arvalid,
  output logic                     s_arready,
  input  logic [ADDRESS_WIDTH-1:0] s_araddr,
  output logic                     s_rvalid,
  input  logic                     s_rready,
  output logic [DATA_WIDTH-1:0]    s_rdata,
  output logic [1:0]               s_rresp,
  output logic                     irq
);

  localparam int PRESCALE_WIDTH = 8;

  logic                                          req_valid;
  reg_access_e                                   req_access;
  logic [ADDRESS_WIDTH-1:0]                      req_address;
  logic [DATA_WIDTH-1:0]                         req_write_data;
  logic [DATA_WIDTH/8-1:0]                       req_strobe;
  logic                                          req_ready;
  reg_status_e                                   req_status;
  logic [DATA_WIDTH-1:0]                         req_read_data;
  logic [REGISTERS-1:0]                          slot_valid;
  reg_access_e [REGISTERS-1:0]                   slot_access;
  logic [REGISTERS-1:0][LOCAL_ADDRESS_WIDTH-1:0] slot_address;
  logic [REGISTERS-1:0][DATA_WIDTH-1:0]          slot_write_data;
  logic [REGISTERS-1:0][DATA_WIDTH/8-1:0]        slot_strobe;
  logic [REGISTERS-1:0]                          slot_active;
  logic [REGISTERS-1:0]                          slot_ready;
  reg_status_e [REGISTERS-1:0]                   slot_status;
  logic [REGISTERS-1:0][DATA_WIDTH-1:0]          slot_read_data;
  logic [DATA_WIDTH-1:0]                         ctrl_value;
  logic [DATA_WIDTH-1:0]                         compare_value;
  logic [DATA_WIDTH-1:0]                         status_value;
  logic                                          tmr_enable;
  logic [PRESCALE_WIDTH-1:0]                     tmr_prescale;
  logic [DATA_WIDTH-1:0]                         tmr_count;
  logic                                          tmr_match_pulse;

  assign tmr_enable   = ctrl_value[CTRL_ENABLE_BIT];
  assign tmr_prescale = ctrl_value[CTRL_PRESCALE_LSB+:PRESCALE_WIDTH];
  assign irq          = status_value[0]; // sticky match flag

  axi_lite_adapter #(
    .ADDRESS_WIDTH (ADDRESS_WIDTH),
    .DATA_WIDTH    (DATA_WIDTH)
  ) u_adapter (
    .i_clk, .i_rst_n,
    .s_awvalid, .s_awready, .s_awaddr,
    .s_wvalid, .s_wready, .s_wdata, .s_wstrb,
    .s_bvalid, .s_bready, .s_bresp,
    .s_arvalid, .s_arready, .s_araddr,
    .s_rvalid, .s_rready, .s_rdata, .s_rresp,
    .req_valid, .req_access, .req_address, .req_write_data, .req_strobe,
    .req_ready, .req_status, .req_read_data
  );

  reg_decoder #(
    .ADDRESS_WIDTH       (ADDRESS_WIDTH),
    .LOCAL_ADDRESS_WIDTH (LOCAL_ADDRESS_WIDTH),
    .DATA_WIDTH          (DATA_WIDTH),
    .REGISTERS           (REGISTERS),
    .BASE_ADDRESS        (BASE_ADDRESS),
    .BYTE_SIZE           (BYTE_SIZE),
    .ERROR_STATUS        (ERROR_STATUS),
    .DEFAULT_READ_DATA   (DEFAULT_READ_DATA)
  ) u_decoder (
    .i_clk, .i_rst_n,
    .req_valid, .req_access, .req_address, .req_write_data, .req_strobe,
    .req_ready, .req_status, .req_read_data,
    .slot_valid, .slot_access, .slot_address, .slot_write_data, .slot_strobe,
    .slot_active, .slot_ready, .slot_status, .slot_read_data
  );

  reg_slot #(
    .LOCAL_ADDRESS_WIDTH (LOCAL_ADDRESS_WIDTH),
    .DATA_WIDTH          (DATA_WIDTH),
    .OFFSET              (CTRL_OFFSET),
    .RESET_VALUE         ('0),
    .WRITE_MASK          (32'h0000_ff01),
    .W1C_MASK            ('0)
  ) u_ctrl (
    .i_clk, .i_rst_n,
    .slot_valid      (slot_valid[0]),
    .slot_access     (slot_access[0]),
    .slot_address    (slot_address[0]),
    .slot_write_data (slot_write_data[0]),
    .slot_strobe     (slot_strobe[0]),
    .slot_active     (slot_active[0]),
    .slot_ready      (slot_ready[0]),
    .slot_status     (slot_status[0]),
    .slot_read_data  (slot_read_data[0]),
    .hw_value        ('0),
    .hw_set          ('0),
    .value           (ctrl_value)
  );

  reg_slot #(
    .LOCAL_ADDRESS_WIDTH (LOCAL_ADDRESS_WIDTH),
    .DATA_WIDTH          (DATA_WIDTH),
    .OFFSET              (COMPARE_OFFSET),
    .RESET_VALUE         ('0),
    .WRITE_MASK          ('1),
    .W1C_MASK            ('0)
  ) u_compare (
    .i_clk, .i_rst_n,
    .slot_valid      (slot_valid[1]),
    .slot_access     (slot_access[1]),
    .slot_address    (slot_address[1]),
    .slot_write_data (slot_write_data[1]),
    .slot_strobe     (slot_strobe[1]),
    .slot_active     (slot_active[1]),
    .slot_ready      (slot_ready[1]),
    .slot_status     (slot_status[1]),
    .slot_read_data  (slot_read_data[1]),
    .hw_value        ('0),
    .hw_set          ('0),
    .value           (compare_value)
  );

  reg_slot #(
    .LOCAL_ADDRESS_WIDTH (LOCAL_ADDRESS_WIDTH),
    .DATA_WIDTH          (DATA_WIDTH),
    .OFFSET              (COUNT_OFFSET),
    .RESET_VALUE         ('0),
    .WRITE_MASK          ('0), // read-only live count
    .W1C_MASK            ('0)
  ) u_count (
    .i_clk, .i_rst_n,
    .slot_valid      (slot_valid[2]),
    .slot_access     (slot_access[2]),
    .slot_address    (slot_address[2]),
    .slot_write_data (slot_write_data[2]),
    .slot_strobe     (slot_strobe[2]),
    .slot_active     (slot_active[2]),
    .slot_ready      (slot_ready[2]),
    .slot_status     (slot_status[2]),
    .slot_read_data  (slot_read_data[2]),
    .hw_value        (tmr_count),
    .hw_set          ('0),
    .value           ()
  );

  reg_slot #(
    .LOCAL_ADDRESS_WIDTH (LOCAL_ADDRESS_WIDTH),
    .DATA_WIDTH          (DATA_WIDTH),
    .OFFSET              (STATUS_OFFSET),
    .RESET_VALUE         ('0),
    .WRITE_MASK          ('0),
    .W1C_MASK            (32'h0000_0001)
  ) u_status (
    .i_clk, .i_rst_n,
    .slot_valid      (slot_valid[3]),
    .slot_access     (slot_access[3]),
    .slot_address    (slot_address[3]),
    .slot_write_data (slot_write_data[3]),
    .slot_strobe     (slot_strobe[3]),
    .slot_active     (slot_active[3]),
    .slot_ready      (slot_ready[3]),
    .slot_status     (slot_status[3]),
    .slot_read_data  (slot_read_data[3]),
    .hw_value        ('0),
    .hw_set          ({{(DATA_WIDTH-1){1'b0}}, tmr_match_pulse}),
    .value           (status_value)
  );

  timer_core #(
    .DATA_WIDTH     (DATA_WIDTH),
    .PRESCALE_WIDTH (PRESCALE_WIDTH)
  ) u_timer (
    .i_clk, .i_rst_n,
    .tmr_enable,
    .tmr_prescale,
    .tmr_compare     (compare_value),
    .tmr_count,
    .tmr_match_pulse
  );

endmodule

// ==== tests/tb_timer_top.sv ====
`timescale 1ns/1ns
module tb_timer_top
  import regbus_pkg::*;
;

  localparam logic [15:0] BASE_ADDRESS   = 16'h0100;
  localparam logic [31:0] CTRL_MASK      = 32'h0000_ff01;
  localparam logic [31:0] DEFAULT_DATA   = 32'hdead_beef;
  localparam int          TIMEOUT_CYCLES = 200;

  logic        i_clk;
  logic        i_rst_n;
  logic        s_awvalid;
  logic        s_awready;
  logic [15:0] s_awaddr;
  logic        s_wvalid;
  logic        s_wready;
  logic [31:0] s_wdata;
  logic [3:0]  s_wstrb;
  logic        s_bvalid;
  logic        s_bready;
  logic [1:0]  s_bresp;
  logic        s_arvalid;
  logic        s_arready;
  logic [15:0] s_araddr;
  logic        s_rvalid;
  logic        s_rready;
  logic [31:0] s_rdata;
  logic [1:0]  s_rresp;
  logic        irq;
  logic        timed_out;
  int          checks;
  int          errors;

  timer_top UUT (
    .i_clk, .i_rst_n,
    .s_awvalid, .s_awready, .s_awaddr,
    .s_wvalid, .s_wready, .s_wdata, .s_wstrb,
    .s_bvalid, .s_bready, .s_bresp,
    .s_arvalid, .s_arready, .s_araddr,
    .s_rvalid, .s_rready, .s_rdata, .s_rresp,
    .irq
  );

  initial i_clk = 1'b0;
  always #20 i_clk = ~i_clk;

  // ends the run once a handshake wait has given up
  initial begin
    wait (timed_out);
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("[ERROR] %0t ns %s expected 0x%08h actual 0x%08h", $time, name, expected, actual);
    end
  endtask

  task automatic check_at_most(input string name, input logic [31:0] limit,
                               input logic [31:0] actual);
    checks++;
    assert (actual <= limit) else begin
      errors++;
      $display("[ERROR] %0t ns %s expected <= 0x%08h actual 0x%08h", $time, name, limit, actual);
    end
  endtask

  task automatic wait_high(input int sel, input string what);
    int   cycles;
    logic seen;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(negedge i_clk); // outputs settled here
      case (sel)
        0: seen = s_arready;
        1: seen = s_rvalid;
        2: seen = s_awready && s_wready;
        default: seen = s_bvalid;
      endcase
      cycles++;
    end
    if (!seen) begin
      $display("timeout: %s stayed low for %0d cycles", what, TIMEOUT_CYCLES);
      timed_out = 1'b1;
      forever @(posedge i_clk);
    end
  endtask

  task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge i_clk);
    s_arvalid <= 1'b1;
    s_araddr  <= addr;
    wait_high(0, "s_arready");
    @(posedge i_clk);
    s_arvalid <= 1'b0;
    s_rready  <= 1'b1;
    wait_high(1, "s_rvalid");
    data = s_rdata;
    resp = s_rresp;
    @(posedge i_clk);
    s_rready <= 1'b0;
  endtask

  task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] strobe, output logic [1:0] resp);
    @(posedge i_clk);
    s_awvalid <= 1'b1;
    s_awaddr  <= addr;
    s_wvalid  <= 1'b1;
    s_wdata   <= data;
    s_wstrb   <= strobe;
    wait_high(2, "s_awready and s_wready");
    @(posedge i_clk);
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
    s_bready  <= 1'b1;
    wait_high(3, "s_bvalid");
    resp = s_bresp;
    @(posedge i_clk);
    s_bready <= 1'b0;
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_value,
                                              input logic [31:0] data, input logic [3:0] strobe);
    logic [31:0] result;
    result = old_value;
    for (int i = 0; i < 4; i++) begin
      if (strobe[i]) begin
        result[8*i+:8] = data[8*i+:8];
      end
    end
    return result;
  endfunction

  task automatic end_test(input string name, input int errors_before);
    $display("test %-12s %s", name, (errors == errors_before) ? "ok" : "errors found");
  endtask

  initial begin
    int unsigned    seed_value;
    int             errors_before;
    logic [31:0]    data;
    logic [31:0]    ctrl_model;
    logic [31:0]    compare_model;
    logic [31:0]    count_before;
    logic [3:0]     strobe;
    logic [7:0]     prescale;
    logic [1:0]     resp;
    logic [15:0]    bad_addr [3];
    logic           irq_seen;
    seed_value = $urandom(32'hc2d8_70c6);
    timed_out = 1'b0;
    checks = 0;
    errors = 0;
    ctrl_model = '0;
    compare_model = '0;
    bad_addr[0] = 16'h0200; // outside the window
    bad_addr[1] = BASE_ADDRESS + 16'h0006; // unaligned hole
    bad_addr[2] = BASE_ADDRESS + 16'h0010; // just past the end
    i_rst_n   <= 1'b0;
    s_awvalid <= 1'b0;
    s_awaddr  <= '0;
    s_wvalid  <= 1'b0;
    s_wdata   <= '0;
    s_wstrb   <= '0;
    s_bready  <= 1'b0;
    s_arvalid <= 1'b0;
    s_araddr  <= '0;
    s_rready  <= 1'b0;
    repeat (8) @(posedge i_clk);
    i_rst_n <= 1'b1;

    errors_before = errors;
    @(negedge i_clk);
    check_value("irq", 32'h0, {31'b0, irq});
    for (int i = 0; i < 4; i++) begin
      axi_read(BASE_ADDRESS + 16'(4 * i), data, resp);
      check_value("s_rdata", 32'h0, data);
      check_value("s_rresp", 32'(STATUS_OKAY), {30'b0, resp});
    end
    end_test("reset", errors_before);

    errors_before = errors;
    for (int i = 0; i < 8; i++) begin
      data = $urandom();
      strobe = 4'($urandom());
      if ($urandom_range(1, 0) == 0) begin
        data[CTRL_ENABLE_BIT] = 1'b0; // keep the timer stopped
        axi_write(BASE_ADDRESS + 16'(CTRL_OFFSET), data, strobe, resp);
        ctrl_model = merge_bytes(ctrl_model, data, strobe) & CTRL_MASK;
      end else begin
        axi_write(BASE_ADDRESS + 16'(COMPARE_OFFSET), data, strobe, resp);
        compare_model = merge_bytes(compare_model, data, strobe);
      end
      check_value("s_bresp", 32'(STATUS_OKAY), {30'b0, resp});
      axi_read(BASE_ADDRESS + 16'(CTRL_OFFSET), data, resp);
      check_value("CTRL", ctrl_model, data);
      axi_read(BASE_ADDRESS + 16'(COMPARE_OFFSET), data, resp);
      check_value("COMPARE", compare_model, data);
      check_value("s_rresp", 32'(STATUS_OKAY), {30'b0, resp});
    end
    end_test("readback", errors_before);

    errors_before = errors;
    for (int i = 0; i < 3; i++) begin
      axi_read(bad_addr[i], data, resp);
      check_value("s_rdata", DEFAULT_DATA, data);
      check_value("s_rresp", 32'(STATUS_SLVERR), {30'b0, resp});
      axi_write(bad_addr[i], $urandom(), 4'hf, resp);
      check_value("s_bresp", 32'(STATUS_SLVERR), {30'b0, resp});
    end
    axi_read(BASE_ADDRESS + 16'(CTRL_OFFSET), data, resp);
    check_value("CTRL", ctrl_model, data);
    axi_read(BASE_ADDRESS + 16'(COMPARE_OFFSET), data, resp);
    check_value("COMPARE", compare_model, data);
    end_test("unmapped", errors_before);

    errors_before = errors;
    compare_model = $urandom_range(12, 1);
    prescale = 8'($urandom_range(7, 0));
    axi_write(BASE_ADDRESS + 16'(COMPARE_OFFSET), compare_model, 4'hf, resp);
    check_value("irq", 32'h0, {31'b0, irq});
    ctrl_model = {16'b0, prescale, 7'b0, 1'b1};
    axi_write(BASE_ADDRESS + 16'(CTRL_OFFSET), ctrl_model, 4'hf, resp);
    irq_seen = 1'b0;
    for (int i = 0; i < TIMEOUT_CYCLES && !irq_seen; i++) begin
      axi_read(BASE_ADDRESS + 16'(COUNT_OFFSET), data, resp);
      check_at_most("COUNT", compare_model, data);
      @(negedge i_clk);
      irq_seen = irq;
    end
    checks++;
    assert (irq_seen) else begin
      errors++;
      $display("irq never rose while the timer ran to its compare value");
    end
    end_test("match", errors_before);

    errors_before = errors;
    ctrl_model = '0;
    axi_write(BASE_ADDRESS + 16'(CTRL_OFFSET), ctrl_model, 4'hf, resp);
    axi_write(BASE_ADDRESS + 16'(STATUS_OFFSET), 32'h0, 4'hf, resp);
    @(negedge i_clk);
    check_value("irq", 32'h1, {31'b0, irq});
    axi_read(BASE_ADDRESS + 16'(STATUS_OFFSET), data, resp);
    check_value("STATUS", 32'h1, data);
    axi_write(BASE_ADDRESS + 16'(STATUS_OFFSET), 32'h1, 4'hf, resp);
    @(negedge i_clk);
    check_value("irq", 32'h0, {31'b0, irq});
    axi_read(BASE_ADDRESS + 16'(STATUS_OFFSET), data, resp);
    check_value("STATUS", 32'h0, data);
    end_test("status", errors_before);

    errors_before = errors;
    axi_read(BASE_ADDRESS + 16'(COUNT_OFFSET), count_before, resp);
    axi_write(BASE_ADDRESS + 16'(COUNT_OFFSET), $urandom(), 4'($urandom()), resp);
    check_value("s_bresp", 32'(STATUS_OKAY), {30'b0, resp});
    axi_read(BASE_ADDRESS + 16'(COUNT_OFFSET), data, resp);
    check_value("COUNT", count_before, data);
    end_test("count_ro", errors_before);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
common/regbus_pkg.sv
axi_lite/axi_lite_adapter.sv
src/reg_decoder.sv
src/reg_slot.sv
timer/timer_core.sv
src/timer_top.sv
tests/tb_timer_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the timer testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_timer_top -f sim.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "result: simulation passed"
  exit 0
else
  echo "result: simulation did not pass"
  exit 1
fi
